//--- design/mmu_pkg.sv
// Shared widths, types and codes; only the five modifying opcodes and six tag vectors are known
package mmu_pkg;

    // ----------------------------------------
    // Address geometry
    // ----------------------------------------
    localparam int PAGE_BITS       = 10;            // Page index width
    localparam int OFFSET_BITS     = 10;            // Word offset inside a page
    localparam int BESM6_PAGE_BITS = 5;             // Virtual page bits in BESM-6 mode
    localparam int NUM_PAGES       = 1024;          // Page map and status depth

    typedef logic [PAGE_BITS-1:0]             page_idx_t;   // Virtual or physical page
    typedef logic [PAGE_BITS+OFFSET_BITS-1:0] vaddr_t;      // Virtual address
    typedef logic [PAGE_BITS+OFFSET_BITS-1:0] phys_addr_t;  // Frame, then offset

    // ----------------------------------------
    // Bus operation codes
    // ----------------------------------------
    typedef logic [3:0] bus_opc_t;                  // Arbiter opcode

    // Opcodes that modify memory
    localparam bus_opc_t OPC_CCWR  = 4'd2;          // Instruction cache write
    localparam bus_opc_t OPC_DCWR  = 4'd4;          // Operand cache write
    localparam bus_opc_t OPC_DWR   = 4'd10;         // Result write
    localparam bus_opc_t OPC_RDMWR = 4'd11;         // Read-modify-write
    localparam bus_opc_t OPC_BTRWR = 4'd12;         // Block transfer write

    // ----------------------------------------
    // Word tags
    // ----------------------------------------
    typedef logic [7:0] tag_t;                      // Tag of a memory word

    localparam int TAG_CMD    = 0;                  // Instruction flag
    localparam int TAG_BESM6  = 1;                  // Compatibility mode
    localparam int TAG_NOLOAD = 2;                  // Read protect
    localparam int TAG_PINT   = 7;                  // Program interpretation

    // ----------------------------------------
    // Interrupt vectors
    // ----------------------------------------
    typedef logic [4:0] int_vect_t;                 // Vector number

    localparam int_vect_t VEC_ITAG_PINT = 5'd9;     // PINT on instruction fetch
    localparam int_vect_t VEC_DTAG_PINT = 5'd10;    // PINT on operand load
    localparam int_vect_t VEC_READ_PROT = 5'd11;    // Load from read-protected word
    localparam int_vect_t VEC_NOT_CMD   = 5'd12;    // Fetched word is not an instruction
    localparam int_vect_t VEC_BAD_ACC   = 5'd21;    // Foreign accumulator mode
    localparam int_vect_t VEC_BAD_OP    = 5'd22;    // Foreign operand mode

endpackage

//--- design/addr_translate.sv
// Request stage 1; a map write is seen only by requests on later edges, map has no reset
`timescale 1ns/1ns

module addr_translate import mmu_pkg::*; (
    input  logic       clk,             // Clock
    input  logic       reset,           // Sync reset, active high
    input  logic       i_req,           // Request strobe
    input  vaddr_t     i_vaddr,         // Virtual address
    input  bus_opc_t   i_opc,           // Bus opcode
    input  logic       i_mode_besm6,    // BESM-6 emulation mode
    input  logic       i_no_paging,     // Map bypass
    input  logic       i_map_we,        // Page map write
    input  page_idx_t  i_map_page,      // Virtual page to write
    input  page_idx_t  i_map_frame,     // Frame for that page
    output logic       o_valid,         // Stage 1 strobe
    output phys_addr_t o_phys,          // Translated address
    output bus_opc_t   o_opc            // Opcode, delayed
);

    // ----------------------------------------
    // Page map
    // ----------------------------------------
    page_idx_t pg_map [NUM_PAGES];      // Frame per virtual page

    always_ff @(posedge clk) begin
        if (i_map_we)
            pg_map[i_map_page] <= i_map_frame;  // Console-style map load
    end

    // ----------------------------------------
    // Translation
    // ----------------------------------------
    page_idx_t pg_virt;                 // Selected virtual page
    page_idx_t pg_frame;                // Physical frame

    // BESM-6 uses only the low page bits, zero-extended
    always_comb begin
        if (i_mode_besm6)
            pg_virt = page_idx_t'(i_vaddr[OFFSET_BITS +: BESM6_PAGE_BITS]);
        else
            pg_virt = i_vaddr[OFFSET_BITS +: PAGE_BITS];    // Full page field
    end

    assign pg_frame = i_no_paging ? pg_virt         // Identity when bypassed
                                  : pg_map[pg_virt];// Mapped frame

    // ----------------------------------------
    // Output register
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset)
            o_valid <= 1'b0;
        else
            o_valid <= i_req;           // One cycle behind the request
    end

    always_ff @(posedge clk) begin
        if (i_req) begin
            o_phys <= {pg_frame, i_vaddr[OFFSET_BITS-1:0]}; // Offset passes unchanged
            o_opc  <= i_opc;
        end
    end

    // A map write needs a known page or some entry gets corrupted
    a_map_page_known: assert property (
        @(posedge clk) disable iff (reset)
        i_map_we |-> !$isunknown(i_map_page)
    ) else $error("page map write with unknown page");

endmodule

//--- design/page_status.sv
// Request stage 2; used/dirty bits have no reset, a set beats a clear on the same page and edge
`timescale 1ns/1ns

module page_status import mmu_pkg::*; (
    input  logic       clk,             // Clock
    input  logic       reset,           // Sync reset, active high
    input  logic       i_valid,         // Stage 1 strobe
    input  phys_addr_t i_phys,          // Translated address
    input  bus_opc_t   i_opc,           // Bus opcode
    input  page_idx_t  i_stat_page,     // Status port page
    input  logic       i_stat_clear,    // Clear used and dirty of that page
    output logic       o_stat_used,     // Page referenced
    output logic       o_stat_dirty,    // Page modified
    output logic       o_valid,         // Access issued
    output phys_addr_t o_physad,        // Physical address
    output logic       o_rd,            // Read access
    output logic       o_wr,            // Write access
    output logic       o_atomic         // Read-modify-write
);

    // ----------------------------------------
    // Opcode classification
    // ----------------------------------------
    logic      opc_read;                // Opcode reads memory
    logic      opc_write;               // Opcode writes memory
    logic      opc_atomic;              // Opcode is RDMWR
    page_idx_t pg_frame;                // Frame being accessed

    always_comb begin
        opc_read   = 1'b1;              // Plain read by default
        opc_write  = 1'b0;
        opc_atomic = 1'b0;
        case (i_opc)
            OPC_CCWR,                   // Instruction cache write
            OPC_DCWR,                   // Operand cache write
            OPC_DWR,                    // Result write
            OPC_BTRWR: begin            // Block transfer write
                opc_read  = 1'b0;
                opc_write = 1'b1;
            end
            OPC_RDMWR: begin            // Read-modify-write
                opc_write  = 1'b1;      // Read stays set
                opc_atomic = 1'b1;
            end
            default: begin
                opc_read = 1'b1;
            end
        endcase
    end

    assign pg_frame = i_phys[OFFSET_BITS +: PAGE_BITS];     // Upper field is the frame

    // ----------------------------------------
    // Used and dirty bits
    // ----------------------------------------
    logic pg_used  [NUM_PAGES];         // Page has been referenced
    logic pg_dirty [NUM_PAGES];         // Page has been modified

    always_ff @(posedge clk) begin
        if (i_stat_clear) begin
            pg_used[i_stat_page]  <= 1'b0;
            pg_dirty[i_stat_page] <= 1'b0;
        end
        // Later assignment wins when both hit the same page
        if (i_valid) begin
            pg_used[pg_frame] <= 1'b1;
            if (opc_write)
                pg_dirty[pg_frame] <= 1'b1;
        end
    end

    assign o_stat_used  = pg_used[i_stat_page];     // Combinational read
    assign o_stat_dirty = pg_dirty[i_stat_page];

    // ----------------------------------------
    // Issued access
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            o_valid  <= 1'b0;
            o_rd     <= 1'b0;
            o_wr     <= 1'b0;
            o_atomic <= 1'b0;
        end else begin
            o_valid  <= i_valid;
            o_rd     <= i_valid & opc_read;     // RMW reads too
            o_wr     <= i_valid & opc_write;
            o_atomic <= i_valid & opc_atomic;
        end
    end

    always_ff @(posedge clk) begin
        if (i_valid)
            o_physad <= i_phys;         // Address held until next access
    end

    // Every issued access has a direction, and an atomic one has both
    a_access_class: assert property (
        @(posedge clk) disable iff (reset)
        (o_valid |-> (o_rd | o_wr)) and (o_atomic |-> (o_rd & o_wr))
    ) else $error("issued access with inconsistent rd/wr/atomic");

endmodule

//--- design/tag_check.sv
// Return-side tag checks; a new event overrides a pending vector and beats a same-edge clear
`timescale 1ns/1ns

module tag_check import mmu_pkg::*; (
    input  logic      clk,              // Clock
    input  logic      reset,            // Sync reset, active high
    input  logic      i_fetch_done,     // Instruction fetch returned
    input  logic      i_load_done,      // Operand load returned
    input  tag_t      i_tag,            // Tag of the returned word
    input  logic      i_no_progtag,     // Mask program interpretation
    input  logic      i_no_rtag,        // Mask read protection
    input  logic      i_no_badacc,      // Mask foreign accumulator
    input  logic      i_no_badop,       // Mask foreign operand
    input  logic      i_acc_besm6,      // Accumulator BESM-6 tag bit
    input  logic      i_int_clear,      // Clear pending interrupt
    output logic      o_int,            // Interrupt pending
    output int_vect_t o_int_vect        // Winning vector
);

    // ----------------------------------------
    // Individual checks
    // ----------------------------------------
    logic itag_pint;                    // Fetch, program interpretation
    logic dtag_pint;                    // Load, program interpretation
    logic dtag_noload;                  // Load, read protected
    logic itag_notcmd;                  // Fetch, not an instruction
    logic itag_badacc;                  // Fetch, mode mismatch
    logic dtag_badop;                   // Load, mode mismatch

    assign itag_pint   = i_fetch_done & i_tag[TAG_PINT] & !i_no_progtag;
    assign dtag_pint   = i_load_done & i_tag[TAG_PINT] & !i_no_progtag;
    assign dtag_noload = i_load_done & i_tag[TAG_NOLOAD] & !i_no_rtag;
    assign itag_notcmd = i_fetch_done & !i_tag[TAG_CMD];    // Never masked
    assign itag_badacc = i_fetch_done & (i_tag[TAG_BESM6] != i_acc_besm6) & !i_no_badacc;
    assign dtag_badop  = i_load_done & (i_tag[TAG_BESM6] != i_acc_besm6) & !i_no_badop;

    // ----------------------------------------
    // Priority select
    // ----------------------------------------
    logic      hit;                     // Some check fired
    int_vect_t hit_vect;                // Highest-priority vector

    always_comb begin
        hit      = 1'b1;
        hit_vect = VEC_ITAG_PINT;
        if (itag_pint)
            hit_vect = VEC_ITAG_PINT;
        else if (dtag_pint)
            hit_vect = VEC_DTAG_PINT;
        else if (dtag_noload)
            hit_vect = VEC_READ_PROT;
        else if (itag_notcmd)
            hit_vect = VEC_NOT_CMD;
        else if (itag_badacc)
            hit_vect = VEC_BAD_ACC;
        else if (dtag_badop)
            hit_vect = VEC_BAD_OP;
        else
            hit = 1'b0;                 // Nothing to report
    end

    // ----------------------------------------
    // Interrupt register
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            o_int      <= 1'b0;
            o_int_vect <= '0;
        end else if (hit) begin
            o_int      <= 1'b1;         // Event wins over clear
            o_int_vect <= hit_vect;
        end else if (i_int_clear) begin
            o_int      <= 1'b0;         // Vector kept for inspection
        end
    end

    // The return bus completes one transfer per cycle
    a_one_done: assert property (
        @(posedge clk) disable iff (reset)
        !(i_fetch_done && i_load_done)
    ) else $error("fetch and load completed on the same cycle");

endmodule

//--- design/mmu_top.sv
// Memory-access path top; o_valid follows i_req by two cycles, no back-pressure anywhere
`timescale 1ns/1ns

module mmu_top import mmu_pkg::*; (
    input  logic       clk,             // Clock
    input  logic       reset,           // Sync reset, active high
    // Request side
    input  logic       i_req,           // Request strobe
    input  vaddr_t     i_vaddr,         // Virtual address
    input  bus_opc_t   i_opc,           // Bus opcode
    input  logic       i_mode_besm6,    // BESM-6 emulation mode
    input  logic       i_no_paging,     // Map bypass
    input  logic       i_map_we,        // Page map write
    input  page_idx_t  i_map_page,      // Page to write
    input  page_idx_t  i_map_frame,     // Frame to write
    // Status port
    input  page_idx_t  i_stat_page,     // Page to inspect
    input  logic       i_stat_clear,    // Clear its bits
    output logic       o_stat_used,     // Used bit
    output logic       o_stat_dirty,    // Dirty bit
    // Issued access
    output logic       o_valid,         // Access strobe
    output phys_addr_t o_physad,        // Physical address
    output logic       o_rd,            // Read
    output logic       o_wr,            // Write
    output logic       o_atomic,        // Read-modify-write
    // Return side
    input  logic       i_fetch_done,    // Fetch complete
    input  logic       i_load_done,     // Load complete
    input  tag_t       i_tag,           // Returned tag
    input  logic       i_no_progtag,    // Mask PINT
    input  logic       i_no_rtag,       // Mask read protect
    input  logic       i_no_badacc,     // Mask foreign accumulator
    input  logic       i_no_badop,      // Mask foreign operand
    input  logic       i_acc_besm6,     // Accumulator mode tag
    input  logic       i_int_clear,     // Clear interrupt
    output logic       o_int,           // Interrupt pending
    output int_vect_t  o_int_vect       // Interrupt vector
);

    // ----------------------------------------
    // Stage 1 to stage 2
    // ----------------------------------------
    logic       s1_valid;               // Translated request
    phys_addr_t s1_phys;                // Its physical address
    bus_opc_t   s1_opc;                 // Its opcode

    addr_translate translate_i (
        .clk(clk), .reset(reset),
        .i_req(i_req), .i_vaddr(i_vaddr), .i_opc(i_opc),
        .i_mode_besm6(i_mode_besm6), .i_no_paging(i_no_paging),
        .i_map_we(i_map_we), .i_map_page(i_map_page), .i_map_frame(i_map_frame),
        .o_valid(s1_valid), .o_phys(s1_phys), .o_opc(s1_opc)
    );

    page_status status_i (
        .clk(clk), .reset(reset),
        .i_valid(s1_valid), .i_phys(s1_phys), .i_opc(s1_opc),
        .i_stat_page(i_stat_page), .i_stat_clear(i_stat_clear),
        .o_stat_used(o_stat_used), .o_stat_dirty(o_stat_dirty),
        .o_valid(o_valid), .o_physad(o_physad),
        .o_rd(o_rd), .o_wr(o_wr), .o_atomic(o_atomic)
    );

    // Tag path is independent of the request pipeline
    tag_check tag_i (
        .clk(clk), .reset(reset),
        .i_fetch_done(i_fetch_done), .i_load_done(i_load_done), .i_tag(i_tag),
        .i_no_progtag(i_no_progtag), .i_no_rtag(i_no_rtag),
        .i_no_badacc(i_no_badacc), .i_no_badop(i_no_badop),
        .i_acc_besm6(i_acc_besm6), .i_int_clear(i_int_clear),
        .o_int(o_int), .o_int_vect(o_int_vect)
    );

endmodule

//--- bench/tb_top.sv
// Run from the project root so bench/mmu_stimulus.txt opens; operands hex except WAIT counts
`timescale 1ns/1ns

module tb_top import mmu_pkg::*; ();

    // ----------------------------------------
    // DUT signals
    // ----------------------------------------
    logic       clk, reset;
    logic       i_req, i_mode_besm6, i_no_paging, i_map_we;
    vaddr_t     i_vaddr;
    bus_opc_t   i_opc;
    page_idx_t  i_map_page, i_map_frame, i_stat_page;
    logic       i_stat_clear, o_stat_used, o_stat_dirty;
    logic       o_valid, o_rd, o_wr, o_atomic;
    phys_addr_t o_physad;
    logic       i_fetch_done, i_load_done;
    tag_t       i_tag;
    logic       i_no_progtag, i_no_rtag, i_no_badacc, i_no_badop, i_acc_besm6;
    logic       i_int_clear, o_int;
    int_vect_t  o_int_vect;

    mmu_top dut_i (
        .clk(clk), .reset(reset),
        .i_req(i_req), .i_vaddr(i_vaddr), .i_opc(i_opc),
        .i_mode_besm6(i_mode_besm6), .i_no_paging(i_no_paging),
        .i_map_we(i_map_we), .i_map_page(i_map_page), .i_map_frame(i_map_frame),
        .i_stat_page(i_stat_page), .i_stat_clear(i_stat_clear),
        .o_stat_used(o_stat_used), .o_stat_dirty(o_stat_dirty),
        .o_valid(o_valid), .o_physad(o_physad), .o_rd(o_rd), .o_wr(o_wr), .o_atomic(o_atomic),
        .i_fetch_done(i_fetch_done), .i_load_done(i_load_done), .i_tag(i_tag),
        .i_no_progtag(i_no_progtag), .i_no_rtag(i_no_rtag),
        .i_no_badacc(i_no_badacc), .i_no_badop(i_no_badop),
        .i_acc_besm6(i_acc_besm6), .i_int_clear(i_int_clear),
        .o_int(o_int), .o_int_vect(o_int_vect)
    );

    // ----------------------------------------
    // Bench state
    // ----------------------------------------
    int           cycle_cnt;            // Posedges since time zero
    int           cycle_limit;          // Timeout in cycles
    int           fd;                   // Stimulus file handle
    int           test_errs, test_checks;
    int           tests_passed, tests_failed;
    logic [191:0] cur_test;             // Name of the running test
    phys_addr_t   exp_phys_q [$];       // Expected o_physad per request
    logic [2:0]   exp_cls_q [$];        // Expected {rd, wr, atomic}
    int           exp_due_q [$];        // Cycle in which o_valid is due

    always #10 clk = ~clk;              // 20 ns period

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("Run timed out after %0d cycles in test %0s", cycle_cnt, cur_test);
            $display("Verification failed");
            $finish;
        end
    end

    // ----------------------------------------
    // Checking helpers
    // ----------------------------------------
    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        test_checks++;
        if (expected !== actual) begin
            $display("ERROR %0s %0s expected %h actual %h", cur_test, name, expected, actual);
            test_errs++;
        end
    endtask

    task automatic report_problem(input string msg);
        $display("ERROR %0s: %0s", cur_test, msg);
        test_errs++;
    endtask

    task automatic need_fields(input int got, input int want);
        if (got != want)
            report_problem("stimulus line has missing or unreadable operands");
    endtask

    // Issued accesses are matched in order against the request queue
    always @(negedge clk) begin
        if (!reset) begin
            while (exp_due_q.size() > 0 && exp_due_q[0] < cycle_cnt) begin
                report_problem("expected access never appeared on o_valid");
                exp_due_q.delete(0);
                exp_phys_q.delete(0);
                exp_cls_q.delete(0);
            end
            if (o_valid) begin
                if (exp_due_q.size() == 0 || exp_due_q[0] != cycle_cnt) begin
                    report_problem("o_valid pulsed with no request due in this cycle");
                end else begin
                    check_value("physad", exp_phys_q[0], o_physad);
                    check_value("rd_wr_atomic", exp_cls_q[0], {o_rd, o_wr, o_atomic});
                    exp_due_q.delete(0);
                    exp_phys_q.delete(0);
                    exp_cls_q.delete(0);
                end
            end
        end
    end

    // ----------------------------------------
    // Driving helpers
    // ----------------------------------------
    task automatic clear_pulses();
        i_req        = 1'b0;
        i_map_we     = 1'b0;
        i_stat_clear = 1'b0;
        i_fetch_done = 1'b0;
        i_load_done  = 1'b0;
        i_int_clear  = 1'b0;
    endtask

    task automatic next_cycle();
        @(negedge clk);
        clear_pulses();                 // Pulses last one cycle
    endtask

    task automatic finish_test();
        while (exp_due_q.size() != 0)
            @(negedge clk);             // Let the pipeline drain
        if (test_checks > 0 || test_errs > 0) begin
            if (test_errs == 0) begin
                tests_passed++;
                $display("PASS %0s checks %0d", cur_test, test_checks);
            end else begin
                tests_failed++;
                $display("FAIL %0s errors %0d of %0d checks", cur_test, test_errs, test_checks);
            end
        end
        test_errs   = 0;
        test_checks = 0;
    endtask

    task automatic count_lines();
        string line;
        int    n;
        n = 0;
        while ($fgets(line, fd) > 0)
            n++;
        cycle_limit = 10 * n + 100;
        $fclose(fd);
        fd = $fopen("bench/mmu_stimulus.txt", "r");
    endtask

    // ----------------------------------------
    // Command interpreter
    // ----------------------------------------
    task automatic run_commands();
        logic [127:0] cmd;
        logic [191:0] word;
        logic [31:0]  f0, f1, f2, f3, f4, f5, f6, f7;
        string        rest;
        int           got;
        while ($fscanf(fd, "%s", cmd) == 1) begin
            if (cmd == "#") begin
                got = $fgets(rest, fd);     // Skip comment text
            end else if (cmd == "TEST") begin
                got = $fscanf(fd, "%s", word);
                next_cycle();
                finish_test();
                cur_test = word;
            end else if (cmd == "WAIT") begin
                got = $fscanf(fd, "%d", f0);
                need_fields(got, 1);
                repeat (f0) next_cycle();
            end else if (cmd == "MAP") begin
                got = $fscanf(fd, "%h %h", f0, f1);
                need_fields(got, 2);
                next_cycle();
                i_map_we    = 1'b1;
                i_map_page  = f0[9:0];
                i_map_frame = f1[9:0];
            end else if (cmd == "REQ") begin
                got = $fscanf(fd, "%h %h %h %h %h %h %h %h", f0, f1, f2, f3, f4, f5, f6, f7);
                need_fields(got, 8);
                next_cycle();
                i_req        = 1'b1;
                i_vaddr      = f0[19:0];
                i_opc        = f1[3:0];
                i_mode_besm6 = f2[0];
                i_no_paging  = f3[0];
                exp_phys_q.push_back(f4[19:0]);
                exp_cls_q.push_back({f5[0], f6[0], f7[0]});
                exp_due_q.push_back(cycle_cnt + 2);     // o_valid two edges later
            end else if (cmd == "STAT") begin
                got = $fscanf(fd, "%h %h %h", f0, f1, f2);
                need_fields(got, 3);
                next_cycle();
                i_stat_page = f0[9:0];
                #1;                                     // Combinational read settles
                check_value("stat_used", f1, o_stat_used);
                check_value("stat_dirty", f2, o_stat_dirty);
            end else if (cmd == "CLR") begin
                got = $fscanf(fd, "%h", f0);
                need_fields(got, 1);
                next_cycle();
                i_stat_page  = f0[9:0];
                i_stat_clear = 1'b1;
            end else if (cmd == "TAG") begin
                got = $fscanf(fd, "%s %h %h %h %h %h %h %h %h",
                              word, f0, f1, f2, f3, f4, f5, f6, f7);
                need_fields(got, 9);
                next_cycle();
                i_fetch_done = (word == "F");
                i_load_done  = (word == "L");
                i_tag        = f0[7:0];
                i_no_progtag = f1[0];
                i_no_rtag    = f2[0];
                i_no_badacc  = f3[0];
                i_no_badop   = f4[0];
                i_acc_besm6  = f5[0];
                @(negedge clk);                         // One edge to latch
                check_value("int", f6, o_int);
                check_value("int_vect", f7, o_int_vect);
                clear_pulses();
            end else if (cmd == "ICLR") begin
                got = $fscanf(fd, "%h %h", f0, f1);
                need_fields(got, 2);
                next_cycle();
                i_int_clear = 1'b1;
                @(negedge clk);
                check_value("int", f0, o_int);
                check_value("int_vect", f1, o_int_vect);
                clear_pulses();
            end else begin
                report_problem("unknown command in stimulus file");
            end
        end
        next_cycle();
        finish_test();
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial begin
        clk = 1'b0;
        reset = 1'b1;
        clear_pulses();
        i_vaddr = '0;
        i_opc = '0;
        i_mode_besm6 = 1'b0;
        i_no_paging = 1'b0;
        i_map_page = '0;
        i_map_frame = '0;
        i_stat_page = '0;
        i_tag = '0;
        i_no_progtag = 1'b0;
        i_no_rtag = 1'b0;
        i_no_badacc = 1'b0;
        i_no_badop = 1'b0;
        i_acc_besm6 = 1'b0;
        cycle_cnt = 0;
        cycle_limit = 100;
        test_errs = 0;
        test_checks = 0;
        tests_passed = 0;
        tests_failed = 0;
        cur_test = "setup";
        fd = $fopen("bench/mmu_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file bench/mmu_stimulus.txt");
            $display("Verification failed");
            $finish;
        end else begin
            count_lines();
            repeat (3) @(posedge clk);  // Reset held three cycles
            @(negedge clk);
            reset = 1'b0;
            run_commands();
            $fclose(fd);
            $display("Tests passed %0d failed %0d", tests_passed, tests_failed);
            if (tests_failed == 0 && tests_passed > 0) begin
                $display("Verification passed");
            end else begin
                $display("Verification failed");
            end
            $finish;
        end
    end

endmodule

//--- bench/mmu_stimulus.txt
# MAP page frame | REQ vaddr opc besm6 nopage phys rd wr atomic | STAT page used dirty | CLR page
# TAG F/L tag noprog nortag nobadacc nobadop accbesm6 int vect | ICLR int vect | WAIT n | TEST name
TEST paged_translation
MAP 003 155
MAP 004 2A0
MAP 3FF 001
WAIT 1
REQ 00D2A 1 0 0 5552A 1 0 0
REQ 013FF 0 0 0 A83FF 1 0 0
REQ FFC00 3 0 0 00400 1 0 0
TEST bypass_besm6
REQ 2345A 1 0 1 2345A 1 0 0
REQ 08CFF 1 1 0 554FF 1 0 0
REQ F9001 1 1 0 A8001 1 0 0
REQ F9001 1 1 1 01001 1 0 0
TEST access_class
REQ 04001 0 0 1 04001 1 0 0
REQ 04002 2 0 1 04002 0 1 0
REQ 04003 3 0 1 04003 1 0 0
REQ 04004 4 0 1 04004 0 1 0
REQ 04005 9 0 1 04005 1 0 0
REQ 04006 A 0 1 04006 0 1 0
REQ 04007 B 0 1 04007 1 1 1
REQ 04008 C 0 1 04008 0 1 0
REQ 04009 F 0 1 04009 1 0 0
TEST page_bookkeeping
CLR 020
CLR 021
CLR 022
STAT 020 0 0
STAT 021 0 0
MAP 005 022
REQ 08000 1 0 1 08000 1 0 0
REQ 08400 A 0 1 08400 0 1 0
REQ 01410 B 0 0 08810 1 1 1
WAIT 3
STAT 020 1 0
STAT 021 1 1
STAT 022 1 1
CLR 021
STAT 021 0 0
STAT 020 1 0
TEST tag_priority
TAG F 81 0 0 0 0 0 1 09
TAG L 80 0 0 0 0 0 1 0A
TAG L 04 0 0 0 0 0 1 0B
TAG F 00 0 0 0 0 0 1 0C
TAG F 03 0 0 0 0 0 1 15
TAG L 02 0 0 0 0 0 1 16
TAG F 80 0 0 0 0 0 1 09
TAG L 86 0 0 0 0 0 1 0A
TAG L 06 0 0 0 0 0 1 0B
TAG F 02 0 0 0 0 0 1 0C
TAG L 84 1 0 0 0 0 1 0B
ICLR 0 0B
TAG F 81 1 0 0 0 0 0 0B
TAG L 04 0 1 0 0 0 0 0B
TAG F 03 0 0 1 0 0 0 0B
TAG L 02 0 0 0 1 0 0 0B
TEST int_clear
TAG F 00 0 0 0 0 0 1 0C
ICLR 0 0C
TAG L 02 0 0 0 0 0 1 16
ICLR 0 16
TAG L 04 0 0 0 0 0 1 0B

//--- list.f
design/mmu_pkg.sv
design/addr_translate.sv
design/page_status.sv
design/tag_check.sv
design/mmu_top.sv
bench/tb_top.sv
